// ==== all.f ====
+incdir+bench
hdl/rdReqPkg.sv
hdl/rdCfgRegs.sv
hdl/rdReqSplitter.sv
hdl/rdCreditGate.sv
hdl/rdReqSequencer.sv
hdl/rdTlpFormatter.sv
hdl/rdReqEngine.sv
bench/rdReqTb.sv

// ==== bench/rdReqRef.svh ====
////////////////////////////////////////
// Reference model of the read-request split
// Expected descriptors, header beats and credits
////////////////////////////////////////

`ifndef RD_REQ_REF_SVH
`define RD_REQ_REF_SVH

// Split a transfer into the descriptors the engine must send
function automatic void buildReqList(input hostAddrT base, input xferLenT len,
	input int dwCap, input int maxRr, input tagT tag0, inout reqDescT q[$]);
	reqDescT  d;
	hostAddrT a;
	longint   rem;
	int       linkDw;
	int       capDw;
	int       n;
	int       off;
	int       endOff;
	beT       fMask;
	beT       lMask;
	tagT      tag;
	a      = base;
	rem    = longint'(len);
	tag    = tag0;
	linkDw = (maxRr / 4 == 0) ? 1024 : maxRr / 4;
	capDw  = (dwCap == 0 || dwCap > linkDw) ? linkDw : dwCap;
	while (rem > 0)
	begin
		n = (rem < longint'(capDw * 4)) ? int'(rem) : capDw * 4;
		if (4096 - int'(a[11:0]) < n)
			n = 4096 - int'(a[11:0]);	// Stop at the 4 KB line
		off    = int'(a[1:0]);
		endOff = (off + n) % 4;
		fMask  = 4'hF << off;
		lMask  = 4'hF << endOff;
		lMask  = (endOff == 0) ? 4'hF : ~lMask;
		d.addr  = a;
		d.dwLen = dwLenT'((off + n + 3) / 4);
		d.tag   = tag;
		if ((off + n + 3) / 4 == 1)
		begin
			d.firstBe = fMask & lMask;	// Single DW
			d.lastBe  = 4'h0;
		end
		else
		begin
			d.firstBe = fMask;
			d.lastBe  = lMask;
		end
		q.push_back(d);
		a   = a + hostAddrT'(n);
		rem = rem - longint'(n);
		tag = tag + 8'd1;
	end
endfunction

// Both header beats of one memory read
function automatic void buildBeats(input reqDescT d, input reqIdT id,
	output txBeatT b1, output txBeatT b2);
	logic        fourDw;
	logic [31:0] lo;
	fourDw  = d.addr[63:32] != 32'd0;
	lo      = {d.addr[31:2], 2'b00};
	b1.sop  = 1'b1;
	b1.eop  = 1'b0;
	b1.data = {id, d.tag, d.lastBe, d.firstBe, 2'b00, fourDw, 19'd0, d.dwLen};
	b2.sop  = 1'b0;
	b2.eop  = 1'b1;
	b2.data = fourDw ? {lo, d.addr[63:32]} : {32'd0, lo};
endfunction

// Completion credits needed for the reply to one read
function automatic credReqT refCredits(input dwLenT dl, input logic rcb128);
	credReqT c;
	int      dw;
	dw     = (dl == 10'd0) ? 1024 : int'(dl);
	c.hdr  = credHdrT'(rcb128 ? (dw + 31) / 32 : (dw + 15) / 16);
	c.data = credDataT'((dw + 3) / 4);
	return c;
endfunction

`endif

// ==== bench/rdReqTb.sv ====
////////////////////////////////////////
// Testbench of the read-request engine
// Clock, bus tasks, grant and tag models, beat monitor
////////////////////////////////////////

module rdReqTb;
	timeunit 1ns;
	timeprecision 100ps;
	import rdReqPkg::*;
	`include "rdReqRef.svh"

	logic        cfgClk;
	logic        aRst;
	logic        cfgCyc;
	logic        cfgStb;
	logic        cfgWnR;
	cfgAddrT     cfgAddr;
	cfgDataT     cfgWrData;
	cfgDataT     cfgRdData;
	logic        cfgAck;
	logic [11:0] maxReadReq;
	logic        rcbIs128;
	reqIdT       reqId;
	credHdrT     credLimNh;
	credHdrT     availCh;
	credDataT    availCd;
	logic        credUpd;
	credReqT     credReq;
	logic        tagAvail;
	tagT         tagNum;
	logic        tagPop;
	logic        txReq;
	logic        txGrant;
	logic        txValid;
	txBeatT      txBeat;
	logic        txReady;

	txBeatT  expBeats[$];
	reqDescT reqList[$];
	txBeatT  heldBeat;
	txBeatT  expBeat;
	credReqT expCred;
	tagT     lastTag;
	logic    stallPrev;
	logic    popPending;
	logic    randReady;
	logic    limAuto;
	credHdrT nhCnt;
	int      popCnt;
	int      popTarget;
	int      popStart;
	int      grantWait;
	int      errCnt;
	int      testCnt;
	int      testFails;
	int      errMark;

	rdReqEngine DUT
	(
		.i_CfgClk(cfgClk), .i_ARst(aRst),
		.i_CfgCyc(cfgCyc), .i_CfgStb(cfgStb), .i_CfgWnR(cfgWnR),
		.i_CfgAddr(cfgAddr), .i_CfgWrData(cfgWrData),
		.o_CfgRdData(cfgRdData), .o_CfgAck(cfgAck),
		.i_MaxReadReq(maxReadReq), .i_RcbIs128(rcbIs128), .i_ReqId(reqId),
		.i_CredLimNh(credLimNh), .i_AvailCh(availCh), .i_AvailCd(availCd),
		.o_CredUpd(credUpd), .o_CredReq(credReq),
		.i_TagAvail(tagAvail), .i_TagNum(tagNum), .o_TagPop(tagPop),
		.o_TxReq(txReq), .i_TxGrant(txGrant),
		.o_TxValid(txValid), .o_TxBeat(txBeat), .i_TxReady(txReady)
	);

	always #5 cfgClk = ~cfgClk;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	task automatic reportMismatch(input string name, input logic [65:0] exp,
		input logic [65:0] got);
		$display("error t=%0t %s expected %h got %h", $time, name, exp, got);
		errCnt++;
	endtask

	task automatic reportProblem(input string what);
		$display("t=%0t %s", $time, what);
		errCnt++;
	endtask

	task automatic abortOnTimeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic busAccess(input logic wnr, input cfgAddrT a, input cfgDataT wd,
		output cfgDataT rdOut);
		int n = 0;
		@(posedge cfgClk);
		#1;
		cfgCyc    = 1'b1;
		cfgStb    = 1'b1;
		cfgWnR    = wnr;
		cfgAddr   = a;
		cfgWrData = wd;
		@(negedge cfgClk);
		while (!cfgAck)
		begin
			n++;
			if (n > 20)
				abortOnTimeout("configuration acknowledge");
			@(negedge cfgClk);
		end
		rdOut = cfgRdData;
		@(posedge cfgClk);
		#1;
		cfgCyc = 1'b0;
		cfgStb = 1'b0;
		cfgWnR = 1'b0;
		@(negedge cfgClk);
		assert (!cfgAck) else reportProblem("acknowledge lasted more than one cycle");
	endtask

	task automatic regWrite(input cfgAddrT a, input cfgDataT d);
		cfgDataT dummy;
		busAccess(1'b1, a, d, dummy);
	endtask

	task automatic regCheck(input cfgAddrT a, input cfgDataT exp, input string name);
		cfgDataT got;
		busAccess(1'b0, a, '0, got);
		assert (got == exp) else reportMismatch(name, 66'(exp), 66'(got));
	endtask

	// Queue the expected beats, then program and start the engine
	task automatic startTransfer(input hostAddrT base, input xferLenT len, input int cap);
		txBeatT b1;
		txBeatT b2;
		reqList.delete();
		buildReqList(base, len, cap, int'(maxReadReq), tagNum, reqList);
		foreach (reqList[i])
		begin
			buildBeats(reqList[i], reqId, b1, b2);
			expBeats.push_back(b1);
			expBeats.push_back(b2);
		end
		popTarget = popCnt + reqList.size();
		regWrite(CfgRegBaseLo, base[31:0]);
		regWrite(CfgRegBaseHi, base[63:32]);
		regWrite(CfgRegDwCap, cfgDataT'(cap));
		regWrite(CfgRegLength, len);
	endtask

	task automatic finishTransfer();
		int      n = 0;
		cfgDataT st;
		while (popCnt < popTarget || expBeats.size() != 0)
		begin
			n++;
			if (n > 4000)
				abortOnTimeout("the last request of a transfer");
			@(negedge cfgClk);
		end
		n = 0;
		busAccess(1'b0, CfgRegStatus, '0, st);
		while (!st[0])
		begin
			n++;
			if (n > 20)
				abortOnTimeout("the done flag");
			busAccess(1'b0, CfgRegStatus, '0, st);
		end
		regCheck(CfgRegLength, 32'd0, "remaining bytes");
		assert (popCnt == popTarget) else reportMismatch("tag pops", 66'(popTarget), 66'(popCnt));
	endtask

	task automatic endTest(input string name);
		testCnt++;
		if (errCnt == errMark)
			$display("test %0d %s: ok", testCnt, name);
		else
		begin
			testFails++;
			$display("test %0d %s: %0d errors", testCnt, name, errCnt - errMark);
		end
		errMark = errCnt;
	endtask

	////////////////////////////////////////
	// Grant, tag, ready and credit limit models
	////////////////////////////////////////
	always @(posedge cfgClk)
	begin
		#1;
		if (!txReq)
		begin
			txGrant   = 1'b0;
			grantWait = -1;
		end
		else if (!txGrant)
		begin
			if (grantWait < 0)
				grantWait = int'($urandom_range(0, 3));
			if (grantWait == 0)
				txGrant = 1'b1;
			else
				grantWait--;
		end
		if (popPending)
		begin
			tagNum     = tagNum + 8'd1;	// Next tag from the pool
			popPending = 1'b0;
		end
		txReady = randReady ? ($urandom_range(0, 2) != 0) : 1'b1;
		if (limAuto)
			credLimNh = nhCnt + 8'd64;
	end

	// Beat, credit and tag checks on the falling edge
	always @(negedge cfgClk)
	begin
		if (!aRst)
		begin
			assert (!txValid || txReq) else reportProblem("o_TxReq low while a beat is valid");
			if (stallPrev)
			begin
				assert (txValid) else reportProblem("valid dropped under back-pressure");
				assert (txBeat == heldBeat)
					else reportMismatch("o_TxBeat held", heldBeat, txBeat);
			end
			stallPrev = txValid & ~txReady;
			heldBeat  = txBeat;
			if (txValid && txReady)
			begin
				if (expBeats.size() == 0)
					reportProblem("beat sent with no request expected");
				else
				begin
					expBeat = expBeats.pop_front();
					assert (txBeat == expBeat) else reportMismatch("o_TxBeat", expBeat, txBeat);
				end
				if (txBeat.sop)
					lastTag = txBeat.data[47:40];
			end
			if (credUpd)
			begin
				assert (txValid && txReady && txBeat.sop)
					else reportProblem("o_CredUpd without a first beat accepted");
				expCred = refCredits(expBeat.data[9:0], rcbIs128);
				assert (credReq == expCred)
					else reportMismatch("o_CredReq", 66'(expCred), 66'(credReq));
				nhCnt = nhCnt + 8'd1;
			end
			if (tagPop)
			begin
				assert (txValid && txReady && txBeat.eop)
					else reportProblem("o_TagPop without a second beat accepted");
				assert (tagNum == lastTag)
					else reportMismatch("o_TagPop tag", 66'(lastTag), 66'(tagNum));
				popCnt++;
				popPending = 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	initial
	begin
		void'($urandom(35687));
		cfgClk = 1'b0;
		aRst = 1'b1;
		cfgCyc = 1'b0;
		cfgStb = 1'b0;
		cfgWnR = 1'b0;
		cfgAddr = '0;
		cfgWrData = '0;
		maxReadReq = 12'd128;
		rcbIs128 = 1'b0;
		reqId = 16'hBEEF;
		credLimNh = 8'd64;
		availCh = 8'd255;
		availCd = 12'd2000;
		tagAvail = 1'b1;
		tagNum = 8'h10;
		txGrant = 1'b0;
		txReady = 1'b1;
		stallPrev = 1'b0;
		popPending = 1'b0;
		randReady = 1'b0;
		limAuto = 1'b1;
		nhCnt = '0;
		heldBeat = '0;
		expBeat = '0;
		lastTag = '0;
		popCnt = 0;
		popTarget = 0;
		popStart = 0;
		grantWait = -1;
		errCnt = 0;
		testCnt = 0;
		testFails = 0;
		errMark = 0;
		repeat (4) @(posedge cfgClk);
		#1;
		aRst = 1'b0;

		// Reset state and register readback
		@(negedge cfgClk);
		assert (!txValid && !txReq && !tagPop && !credUpd && !cfgAck)
			else reportProblem("outputs not idle after reset");
		regCheck(CfgRegStatus, 32'h3 | (32'(Idle) << 2), "status after reset");
		regWrite(CfgRegBaseLo, 32'h89AB_CDE4);
		regWrite(CfgRegBaseHi, 32'h0123_4567);
		regWrite(CfgRegDwCap, 32'h0000_0155);
		regCheck(CfgRegBaseLo, 32'h89AB_CDE4, "base low");
		regCheck(CfgRegBaseHi, 32'h0123_4567, "base high");
		regCheck(CfgRegDwCap, 32'h0000_0155, "dw cap");
		regWrite(CfgRegConfig, 32'h1);
		endTest("register access");

		popStart = popCnt;
		startTransfer(64'h0000_0000_1000_0000, 32'd512, 0);
		finishTransfer();
		assert (popCnt - popStart == 4)
			else reportMismatch("request count", 66'd4, 66'(popCnt - popStart));
		endTest("aligned 3DW transfer");

		@(posedge cfgClk);
		#1;
		maxReadReq = 12'd512;
		startTransfer(64'h0000_0000_0001_2FA2, 32'd224, 16);	// Ends on a two-byte DW
		finishTransfer();
		endTest("unaligned 4 KB crossing");

		@(posedge cfgClk);
		#1;
		maxReadReq = 12'd128;
		startTransfer(64'h0000_0001_0000_0104, 32'd256, 0);
		finishTransfer();
		endTest("4DW headers");

		// Header credit limit reached, then data credits short
		limAuto = 1'b0;
		@(posedge cfgClk);
		#1;
		credLimNh = nhCnt;
		startTransfer(64'h0000_0000_2000_0000, 32'd256, 0);
		repeat (40)
		begin
			@(negedge cfgClk);
			assert (!txValid) else reportProblem("beat sent with no header credit");
		end
		limAuto = 1'b1;
		finishTransfer();
		@(posedge cfgClk);
		#1;
		rcbIs128 = 1'b1;
		availCd = 12'd4;
		startTransfer(64'h0000_0000_2000_1000, 32'd256, 0);
		repeat (40)
		begin
			@(negedge cfgClk);
			assert (!txValid) else reportProblem("beat sent with data credits short");
		end
		@(posedge cfgClk);
		#1;
		availCd = 12'd2000;
		finishTransfer();
		endTest("credit gating");

		@(posedge cfgClk);
		#1;
		randReady = 1'b1;
		rcbIs128 = 1'b0;
		maxReadReq = 12'd256;
		startTransfer(64'h0000_0000_4000_0F08, 32'd1000, 0);
		finishTransfer();
		randReady = 1'b0;
		endTest("back-pressure");

		$display("tests %0d, failed tests %0d, errors %0d", testCnt, testFails, errCnt);
		if (errCnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== hdl/rdCfgRegs.sv ====
////////////////////////////////////////
// Configuration bus register file
// Acknowledge, readback and start pulse
////////////////////////////////////////

module rdCfgRegs
(
	input  logic               i_CfgClk,
	input  logic               i_ARst,
	input  logic               i_CfgCyc,
	input  logic               i_CfgStb,
	input  logic               i_CfgWnR,
	input  rdReqPkg::cfgAddrT  i_CfgAddr,
	input  rdReqPkg::cfgDataT  i_CfgWrData,
	output rdReqPkg::cfgDataT  o_CfgRdData,
	output logic               o_CfgAck,
	output rdReqPkg::cfgT      o_Cfg,
	output rdReqPkg::xferLenT  o_LenBytes,
	output logic               o_Start,
	input  rdReqPkg::xferLenT  i_Remain,
	input  rdReqPkg::seqStateT i_State,
	input  logic               i_Done,
	input  logic               i_TagAvail
);
	import rdReqPkg::*;

	cfgT     cfg;
	xferLenT lenBytes;
	logic    cfgAck;
	logic    start;
	logic    access;
	cfgDataT rdData;

	// One access per acknowledge, idle cycle after each ack
	assign access = i_CfgCyc & i_CfgStb & ~cfgAck;

	always_ff @(posedge i_CfgClk or posedge i_ARst)
	begin
		if (i_ARst)
		begin
			cfg      <= '0;
			lenBytes <= '0;
			cfgAck   <= 1'b0;
			start    <= 1'b0;
		end
		else
		begin
			cfgAck <= access;
			start  <= access & i_CfgWnR & (i_CfgAddr == CfgRegLength);	// Length write kicks off
			if (access & i_CfgWnR)
			begin
				case (i_CfgAddr)
					CfgRegConfig:
					begin
						cfg.enable <= i_CfgWrData[0];
						cfg.engRst <= i_CfgWrData[1];
					end
					CfgRegDwCap:  cfg.dwCap           <= i_CfgWrData[10:0];
					CfgRegBaseLo: cfg.baseAddr[31:0]  <= i_CfgWrData;
					CfgRegBaseHi: cfg.baseAddr[63:32] <= i_CfgWrData;
					CfgRegLength: lenBytes            <= i_CfgWrData;
					default: ;	// Status is read only
				endcase
			end
		end
	end

	// Readback
	always_comb
	begin
		case (i_CfgAddr)
			CfgRegConfig: rdData = {30'd0, cfg.engRst, cfg.enable};
			CfgRegStatus: rdData = {25'd0, i_State, i_TagAvail, i_Done};
			CfgRegDwCap:  rdData = {21'd0, cfg.dwCap};
			CfgRegBaseLo: rdData = cfg.baseAddr[31:0];
			CfgRegBaseHi: rdData = cfg.baseAddr[63:32];
			CfgRegLength: rdData = i_Remain;	// Bytes still to request
			default:      rdData = '0;
		endcase
	end

	assign o_CfgRdData = rdData;
	assign o_CfgAck    = cfgAck;
	assign o_Cfg       = cfg;
	assign o_LenBytes  = lenBytes;
	assign o_Start     = start;

endmodule

// ==== hdl/rdCreditGate.sv ====
////////////////////////////////////////
// Completion credits for one read request
// Non-posted header accounting and send permission
////////////////////////////////////////

module rdCreditGate
(
	input  logic               i_CfgClk,
	input  logic               i_ARst,
	input  rdReqPkg::dwLenT    i_DwLen,
	input  logic               i_RcbIs128,
	input  rdReqPkg::credHdrT  i_CredLimNh,
	input  rdReqPkg::credHdrT  i_AvailCh,
	input  rdReqPkg::credDataT i_AvailCd,
	input  logic               i_Consume,
	output logic               o_CredOk,
	output rdReqPkg::credReqT  o_CredReq
);
	import rdReqPkg::*;

	logic [10:0] dwCount;
	logic [10:0] chSum64;
	logic [10:0] chSum128;
	logic [10:0] cdSum;
	credReqT     credReq;
	credHdrT     nhConsumed;
	credHdrT     nhSlack;
	logic        nhOk;
	logic        chOk;
	logic        cdOk;
	logic        credOk;

	assign dwCount  = (i_DwLen == '0) ? 11'd1024 : {1'b0, i_DwLen};
	assign chSum64  = dwCount + 11'd15;	// Round up to a 64-byte RCB
	assign chSum128 = dwCount + 11'd31;
	assign cdSum    = dwCount + 11'd3;	// 16 bytes per data credit

	assign credReq.hdr  = i_RcbIs128 ? {2'd0, chSum128[10:5]} : {1'b0, chSum64[10:4]};
	assign credReq.data = {3'd0, cdSum[10:2]};

	// Limit minus what this request would make consumed, modulo 256
	assign nhSlack = i_CredLimNh - (nhConsumed + 8'd1);
	assign nhOk    = nhSlack < NhCreditWindow;
	assign chOk    = i_AvailCh >= credReq.hdr;
	assign cdOk    = i_AvailCd >= credReq.data;

	always_ff @(posedge i_CfgClk or posedge i_ARst)
	begin
		if (i_ARst)
		begin
			nhConsumed <= '0;
			credOk     <= 1'b0;
		end
		else
		begin
			if (i_Consume)
				nhConsumed <= nhConsumed + 8'd1;	// One header per read
			credOk <= nhOk & chOk & cdOk;
		end
	end

	assign o_CredOk  = credOk;
	assign o_CredReq = credReq;

endmodule

// ==== hdl/rdReqEngine.sv ====
////////////////////////////////////////
// Read-request engine top level
////////////////////////////////////////

module rdReqEngine
(
	input  logic               i_CfgClk,
	input  logic               i_ARst,
	input  logic               i_CfgCyc,
	input  logic               i_CfgStb,
	input  logic               i_CfgWnR,
	input  rdReqPkg::cfgAddrT  i_CfgAddr,
	input  rdReqPkg::cfgDataT  i_CfgWrData,
	output rdReqPkg::cfgDataT  o_CfgRdData,
	output logic               o_CfgAck,
	input  logic [11:0]        i_MaxReadReq,
	input  logic               i_RcbIs128,
	input  rdReqPkg::reqIdT    i_ReqId,
	input  rdReqPkg::credHdrT  i_CredLimNh,
	input  rdReqPkg::credHdrT  i_AvailCh,
	input  rdReqPkg::credDataT i_AvailCd,
	output logic               o_CredUpd,
	output rdReqPkg::credReqT  o_CredReq,
	input  logic               i_TagAvail,
	input  rdReqPkg::tagT      i_TagNum,
	output logic               o_TagPop,
	output logic               o_TxReq,
	input  logic               i_TxGrant,
	output logic               o_TxValid,
	output rdReqPkg::txBeatT   o_TxBeat,
	input  logic               i_TxReady
);
	import rdReqPkg::*;

	cfgT      cfg;
	xferLenT  lenBytes;
	xferLenT  remain;
	seqStateT state;
	hostAddrT addr;
	byteLenT  nextLen;
	reqDescT  desc;
	dwLenT    dwLen;
	logic     start;
	logic     done;
	logic     load;
	logic     advance;
	logic     consume;
	logic     descValid;
	logic     credOk;
	logic     beatAccept;
	logic     lastBeat;

	rdCfgRegs uCfgRegs
	(
		.i_CfgClk    (i_CfgClk),
		.i_ARst      (i_ARst),
		.i_CfgCyc    (i_CfgCyc),
		.i_CfgStb    (i_CfgStb),
		.i_CfgWnR    (i_CfgWnR),
		.i_CfgAddr   (i_CfgAddr),
		.i_CfgWrData (i_CfgWrData),
		.o_CfgRdData (o_CfgRdData),
		.o_CfgAck    (o_CfgAck),
		.o_Cfg       (cfg),
		.o_LenBytes  (lenBytes),
		.o_Start     (start),
		.i_Remain    (remain),
		.i_State     (state),
		.i_Done      (done),
		.i_TagAvail  (i_TagAvail)
	);

	rdReqSplitter uSplitter
	(
		.i_CfgClk     (i_CfgClk),
		.i_ARst       (i_ARst),
		.i_Cfg        (cfg),
		.i_LenBytes   (lenBytes),
		.i_MaxReadReq (i_MaxReadReq),
		.i_Load       (load),
		.i_Advance    (advance),
		.o_Addr       (addr),
		.o_NextLen    (nextLen),
		.o_Remain     (remain)
	);

	rdCreditGate uCreditGate
	(
		.i_CfgClk    (i_CfgClk),
		.i_ARst      (i_ARst),
		.i_DwLen     (dwLen),
		.i_RcbIs128  (i_RcbIs128),
		.i_CredLimNh (i_CredLimNh),
		.i_AvailCh   (i_AvailCh),
		.i_AvailCd   (i_AvailCd),
		.i_Consume   (consume),
		.o_CredOk    (credOk),
		.o_CredReq   (o_CredReq)
	);

	rdReqSequencer uSequencer
	(
		.i_CfgClk     (i_CfgClk),
		.i_ARst       (i_ARst),
		.i_Cfg        (cfg),
		.i_Start      (start),
		.i_Addr       (addr),
		.i_NextLen    (nextLen),
		.i_Remain     (remain),
		.i_TagAvail   (i_TagAvail),
		.i_TagNum     (i_TagNum),
		.i_TxGrant    (i_TxGrant),
		.i_CredOk     (credOk),
		.i_BeatAccept (beatAccept),
		.i_LastBeat   (lastBeat),
		.o_Load       (load),
		.o_Advance    (advance),
		.o_Consume    (consume),
		.o_Desc       (desc),
		.o_DescValid  (descValid),
		.o_TxReq      (o_TxReq),
		.o_TagPop     (o_TagPop),
		.o_CredUpd    (o_CredUpd),
		.o_DwLen      (dwLen),
		.o_State      (state),
		.o_Done       (done)
	);

	rdTlpFormatter uFormatter
	(
		.i_CfgClk     (i_CfgClk),
		.i_ARst       (i_ARst),
		.i_Desc       (desc),
		.i_DescValid  (descValid),
		.i_ReqId      (i_ReqId),
		.i_TxReady    (i_TxReady),
		.o_TxValid    (o_TxValid),
		.o_TxBeat     (o_TxBeat),
		.o_BeatAccept (beatAccept),
		.o_LastBeat   (lastBeat)
	);

endmodule

// ==== hdl/rdReqPkg.sv ====
////////////////////////////////////////
// Widths, structs and state enum of the read-request engine
// Configuration register map and credit window
////////////////////////////////////////

package rdReqPkg;

	typedef logic [63:0] hostAddrT;
	typedef logic [12:0] byteLenT;	// Up to 4096
	typedef logic [9:0]  dwLenT;	// 0 means 1024
	typedef logic [31:0] xferLenT;
	typedef logic [7:0]  credHdrT;
	typedef logic [11:0] credDataT;
	typedef logic [7:0]  tagT;
	typedef logic [3:0]  beT;
	typedef logic [15:0] reqIdT;
	typedef logic [3:0]  cfgAddrT;
	typedef logic [31:0] cfgDataT;

	typedef struct packed {
		logic        enable;
		logic        engRst;
		hostAddrT    baseAddr;
		logic [10:0] dwCap;	// 0 selects the link maximum
	} cfgT;

	typedef struct packed {
		hostAddrT addr;
		dwLenT    dwLen;
		beT       firstBe;
		beT       lastBe;
		tagT      tag;
	} reqDescT;

	typedef struct packed {
		logic        sop;
		logic        eop;
		logic [63:0] data;
	} txBeatT;

	typedef struct packed {
		credHdrT  hdr;
		credDataT data;
	} credReqT;

	// One-hot, read back in the status register
	typedef enum logic [4:0] {
		Idle        = 5'b00001,
		Arbitrate   = 5'b00010,
		CheckCredit = 5'b00100,
		Send        = 5'b01000,
		Settle      = 5'b10000
	} seqStateT;

	////////////////////////////////////////
	// Register map
	////////////////////////////////////////
	localparam cfgAddrT CfgRegConfig = 4'd0;
	localparam cfgAddrT CfgRegStatus = 4'd1;
	localparam cfgAddrT CfgRegDwCap  = 4'd2;
	localparam cfgAddrT CfgRegBaseLo = 4'd4;
	localparam cfgAddrT CfgRegBaseHi = 4'd5;
	localparam cfgAddrT CfgRegLength = 4'd7;

	localparam credHdrT NhCreditWindow = 8'd128;	// Modular limit test

endpackage

// ==== hdl/rdReqSequencer.sv ====
////////////////////////////////////////
// Request FSM with tag, arbitration and credit steps
// Descriptor and byte enables of each read
////////////////////////////////////////

module rdReqSequencer
(
	input  logic               i_CfgClk,
	input  logic               i_ARst,
	input  rdReqPkg::cfgT      i_Cfg,
	input  logic               i_Start,
	input  rdReqPkg::hostAddrT i_Addr,
	input  rdReqPkg::byteLenT  i_NextLen,
	input  rdReqPkg::xferLenT  i_Remain,
	input  logic               i_TagAvail,
	input  rdReqPkg::tagT      i_TagNum,
	input  logic               i_TxGrant,
	input  logic               i_CredOk,
	input  logic               i_BeatAccept,
	input  logic               i_LastBeat,
	output logic               o_Load,
	output logic               o_Advance,
	output logic               o_Consume,
	output rdReqPkg::reqDescT  o_Desc,
	output logic               o_DescValid,
	output logic               o_TxReq,
	output logic               o_TagPop,
	output logic               o_CredUpd,
	output rdReqPkg::dwLenT    o_DwLen,
	output rdReqPkg::seqStateT o_State,
	output logic               o_Done
);
	import rdReqPkg::*;

	seqStateT    state;
	reqDescT     desc;
	logic        done;
	logic        startPend;
	logic        settleCnt;
	logic        takeStart;
	logic        goReq;
	logic        firstAcc;
	logic        lastAcc;
	logic [12:0] spanBytes;
	logic [1:0]  endOff;
	logic        oneDw;
	beT          firstBe;
	beT          lastMask;

	// Byte offset plus length gives the DW span of the request
	assign spanBytes = {11'd0, i_Addr[1:0]} + i_NextLen + 13'd3;
	assign oneDw     = spanBytes[12:2] == 11'd1;
	assign endOff    = i_Addr[1:0] + i_NextLen[1:0];
	assign firstBe   = 4'hF << i_Addr[1:0];
	assign lastMask  = (endOff == 2'd0) ? 4'hF : ~(4'hF << endOff);

	// New transfer only once the previous one is done
	assign takeStart = (state == Idle) & startPend & done & ~i_Cfg.engRst;
	assign goReq     = (state == Idle) & ~takeStart & ~done & i_Cfg.enable & ~i_Cfg.engRst &
		(i_NextLen != '0) & i_TagAvail;
	assign firstAcc  = (state == Send) & i_BeatAccept & ~i_LastBeat;
	assign lastAcc   = (state == Send) & i_BeatAccept & i_LastBeat;

	always_ff @(posedge i_CfgClk or posedge i_ARst)
	begin
		if (i_ARst)
		begin
			state     <= Idle;
			done      <= 1'b1;
			startPend <= 1'b0;
			settleCnt <= 1'b0;
		end
		else
		begin
			if (i_Start)
				startPend <= 1'b1;
			else if (takeStart | ((state == Idle) & i_Cfg.engRst))
				startPend <= 1'b0;

			case (state)
				Idle:
				begin
					if (i_Cfg.engRst)
						done <= 1'b1;	// Drops the current transfer
					else if (takeStart)
					begin
						done  <= 1'b0;
						state <= Settle;
					end
					else if (goReq)
						state <= Arbitrate;
				end
				Arbitrate:   if (i_TxGrant) state <= CheckCredit;
				CheckCredit: if (i_CredOk) state <= Send;
				Send:        if (lastAcc) state <= Settle;
				Settle:
				begin
					// Two cycles for the splitter pipeline
					settleCnt <= ~settleCnt;
					if (settleCnt)
					begin
						state <= Idle;
						done  <= (i_Remain == '0);
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	// Descriptor, taken with the tag when leaving Idle
	always_ff @(posedge i_CfgClk)
	begin
		if (goReq)
		begin
			desc.addr    <= i_Addr;
			desc.dwLen   <= spanBytes[11:2];	// 1024 wraps to 0
			desc.firstBe <= oneDw ? (firstBe & lastMask) : firstBe;
			desc.lastBe  <= oneDw ? 4'h0 : lastMask;
			desc.tag     <= i_TagNum;
		end
	end

	assign o_Load      = takeStart;
	assign o_Advance   = lastAcc;
	assign o_Consume   = firstAcc;
	assign o_CredUpd   = firstAcc;
	assign o_TagPop    = lastAcc;
	assign o_Desc      = desc;
	assign o_DescValid = state == Send;
	assign o_TxReq     = (state == Arbitrate) | (state == CheckCredit) | (state == Send);
	assign o_DwLen     = desc.dwLen;
	assign o_State     = state;
	assign o_Done      = done;

endmodule

// ==== hdl/rdReqSplitter.sv ====
////////////////////////////////////////
// Pull address and remaining-byte tracking
// Next request length in two stages
////////////////////////////////////////

module rdReqSplitter
(
	input  logic               i_CfgClk,
	input  logic               i_ARst,
	input  rdReqPkg::cfgT      i_Cfg,
	input  rdReqPkg::xferLenT  i_LenBytes,
	input  logic [11:0]        i_MaxReadReq,
	input  logic               i_Load,
	input  logic               i_Advance,
	output rdReqPkg::hostAddrT o_Addr,
	output rdReqPkg::byteLenT  o_NextLen,
	output rdReqPkg::xferLenT  o_Remain
);
	import rdReqPkg::*;

	hostAddrT    addr;
	xferLenT     remain;
	byteLenT     nextLen;
	byteLenT     distTo4k;
	byteLenT     capOrRemain;
	logic [10:0] linkMaxDw;
	logic [10:0] effCapDw;
	byteLenT     capBytes;
	logic        capUnset;

	////////////////////////////////////////
	// Effective request cap
	////////////////////////////////////////
	// A link maximum of zero stands for 4096 bytes
	assign linkMaxDw = (i_MaxReadReq[11:2] == 10'd0) ? 11'd1024 : {1'b0, i_MaxReadReq[11:2]};
	assign capUnset  = (i_Cfg.dwCap == 11'd0) || (i_Cfg.dwCap > linkMaxDw);
	assign effCapDw  = capUnset ? linkMaxDw : i_Cfg.dwCap;
	assign capBytes  = {effCapDw, 2'b00};

	// Tracking, load wins over advance
	always_ff @(posedge i_CfgClk or posedge i_ARst)
	begin
		if (i_ARst)
		begin
			addr   <= '0;
			remain <= '0;
		end
		else if (i_Load)
		begin
			addr   <= i_Cfg.baseAddr;
			remain <= i_LenBytes;
		end
		else if (i_Advance)
		begin
			addr   <= addr + {51'd0, nextLen};
			remain <= remain - {19'd0, nextLen};
		end
	end

	////////////////////////////////////////
	// Next length pipeline
	////////////////////////////////////////
	always_ff @(posedge i_CfgClk or posedge i_ARst)
	begin
		if (i_ARst)
		begin
			distTo4k    <= '0;
			capOrRemain <= '0;
			nextLen     <= '0;
		end
		else
		begin
			// Stage 1
			distTo4k    <= 13'h1000 - {1'b0, addr[11:0]};
			capOrRemain <= (remain >= {19'd0, capBytes}) ? capBytes : remain[12:0];
			// Stage 2, never crosses 4 KB
			nextLen     <= (distTo4k < capOrRemain) ? distTo4k : capOrRemain;
		end
	end

	assign o_Addr    = addr;
	assign o_NextLen = nextLen;
	assign o_Remain  = remain;

endmodule

// ==== hdl/rdTlpFormatter.sv ====
////////////////////////////////////////
// Memory-read header in two 64-bit beats
// Output register held under back-pressure
////////////////////////////////////////

module rdTlpFormatter
(
	input  logic              i_CfgClk,
	input  logic              i_ARst,
	input  rdReqPkg::reqDescT i_Desc,
	input  logic              i_DescValid,
	input  rdReqPkg::reqIdT   i_ReqId,
	input  logic              i_TxReady,
	output logic              o_TxValid,
	output rdReqPkg::txBeatT  o_TxBeat,
	output logic              o_BeatAccept,
	output logic              o_LastBeat
);
	import rdReqPkg::*;

	logic        is4Dw;
	logic [31:0] dw0;
	logic [31:0] dw1;
	logic [31:0] addrLo;
	txBeatT      beat1;
	txBeatT      beat2;
	txBeatT      beatOut;
	logic        txValid;
	logic        accept;

	////////////////////////////////////////
	// Header fields
	////////////////////////////////////////
	assign is4Dw  = |i_Desc.addr[63:32];	// 64-bit address needs 4DW
	// Fmt in 31:29, type 0 for a memory read
	assign dw0    = {2'b00, is4Dw, 5'b00000, 14'd0, i_Desc.dwLen};
	assign dw1    = {i_ReqId, i_Desc.tag, i_Desc.lastBe, i_Desc.firstBe};
	assign addrLo = {i_Desc.addr[31:2], 2'b00};

	assign beat1.sop  = 1'b1;
	assign beat1.eop  = 1'b0;
	assign beat1.data = {dw1, dw0};

	assign beat2.sop  = 1'b0;
	assign beat2.eop  = 1'b1;
	assign beat2.data = is4Dw ? {addrLo, i_Desc.addr[63:32]} : {32'd0, addrLo};

	assign accept = txValid & i_TxReady;

	always_ff @(posedge i_CfgClk or posedge i_ARst)
	begin
		if (i_ARst)
			txValid <= 1'b0;
		else if (!txValid)
			txValid <= i_DescValid;
		else if (accept & beatOut.eop)
			txValid <= 1'b0;	// Both beats gone
	end

	// Beat changes only when accepted
	always_ff @(posedge i_CfgClk)
	begin
		if (!txValid & i_DescValid)
			beatOut <= beat1;
		else if (accept & beatOut.sop)
			beatOut <= beat2;
	end

	assign o_TxValid    = txValid;
	assign o_TxBeat     = beatOut;
	assign o_BeatAccept = accept;
	assign o_LastBeat   = beatOut.eop;

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the read-request engine testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module rdReqTb -f all.f -o rdReqSim
out=$(./obj_dir/rdReqSim)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED"
